//--- mac_io_params.svh
`ifndef MAC_IO_PARAMS_SVH
`define MAC_IO_PARAMS_SVH

// ======================================================================
// Address map of the 68000 bus (byte addresses)
// ======================================================================
`define MAC_REGION_MASK   24'hF00000  // 1 MB decode granularity
`define MAC_LOW_MASK      24'hC00000  // Low 4 MB window at 0
`define MAC_ROM_BASE      24'h400000  // ROM is always here
`define MAC_RAM_ALT_BASE  24'h600000  // RAM while ROM overlays 0
`define MAC_VIA_BASE      24'hE00000  // VIA region
`define MAC_PERIPH_BIT    23          // Upper half is peripheral space

// ======================================================================
// VIA constants
// ======================================================================
`define MAC_VIA_LOW_BYTE  8'hEF       // Lower data byte on VIA reads
`define MAC_VIA_UNMAPPED  8'hBE       // Unimplemented register index
`define MAC_DDRA_VALUE    8'h7F       // Fixed port A directions
`define MAC_DDRB_FIXED    7'b1000011  // Port B direction bits 7:1
`define MAC_PORTA_RESET   8'h7F       // Bit 4 high so ROM overlays 0
`define MAC_PORTB_RESET   8'hFF
`define MAC_ACR_SHIFT_OUT 3'b111      // ACR[4:2] shift out under clock

// Video timebase
`define MAC_VSYNC_PER_SEC 60

`endif

//--- mac_io_pkg.sv
`default_nettype none

package mac_io_pkg;

  // ======================================================================
  // VIA register index, taken from address bits 12:9
  // ======================================================================
  typedef enum logic [3:0] {
    VIA_PORTB    = 4'h0,  // ORB/IRB
    VIA_PORTA_HS = 4'h1,  // Port A with handshake, not used here
    VIA_DDRB     = 4'h2,
    VIA_DDRA     = 4'h3,
    VIA_T1CL     = 4'h4,  // Timer 1 counter low
    VIA_T1CH     = 4'h5,
    VIA_T1LL     = 4'h6,  // Timer 1 latch low
    VIA_T1LH     = 4'h7,
    VIA_T2CL     = 4'h8,  // Low latch on write, count on read
    VIA_T2CH     = 4'h9,  // Loads and arms timer 2
    VIA_SR       = 4'hA,  // Keyboard shift register
    VIA_ACR      = 4'hB,
    VIA_PCR      = 4'hC,
    VIA_IFR      = 4'hD,
    VIA_IER      = 4'hE,
    VIA_PORTA    = 4'hF   // ORA without handshake
  } via_reg_e;

  // Bit positions in IFR and IER
  typedef enum logic [2:0] {
    IRQ_ONESEC   = 3'd0,
    IRQ_VBLANK   = 3'd1,
    IRQ_KEYREADY = 3'd2,
    IRQ_KEYBIT   = 3'd3,
    IRQ_KEYCLK   = 3'd4,
    IRQ_T2       = 3'd5,
    IRQ_T1       = 3'd6
  } via_irq_e;

  localparam int VIA_IRQ_COUNT = 7;

  // Flag or enable vector, one bit per via_irq_e
  typedef logic [VIA_IRQ_COUNT-1:0] via_flags_t;

endpackage

`default_nettype wire

//--- cpu_bus_if.sv
`default_nettype none

// One decoded VIA access plus its read data
interface cpu_bus_if import mac_io_pkg::*; ();

  logic       sel;      // VIA region while address strobe low
  logic       write;    // CPU write cycle
  via_reg_e   reg_idx;  // From address bits 12:9
  logic [7:0] wdata;    // Upper CPU data byte
  logic       upper;    // Upper data strobe active
  logic [7:0] rdata;    // Register read value

  modport decoder (
    output sel,
    output write,
    output reg_idx,
    output wdata,
    output upper,
    input  rdata
  );

  modport via (
    input  sel,
    input  write,
    input  reg_idx,
    input  wdata,
    input  upper,
    output rdata
  );

endinterface

`default_nettype wire

//--- bus_decode.sv
`default_nettype none
`include "mac_io_params.svh"

module bus_decode import mac_io_pkg::*; (
  input  wire  [23:1] cpu_a,      // 68000 word address
  input  wire         cpu_as_n,   // Address strobe
  input  wire         cpu_rw,     // High for read
  input  wire         cpu_uds_n,  // Upper data strobe
  input  wire  [15:0] cpu_dout,   // Data from CPU
  input  wire  [15:0] ram_dout,
  input  wire  [15:0] rom_dout,
  input  wire         overlay,    // ROM mapped at 0
  output logic        ram_cs,
  output logic        rom_cs,
  output logic        vpa_n,      // Valid peripheral address
  output logic [23:0] ram_addr,   // Byte address relative to RAM base
  output logic [15:0] cpu_din,    // Data to CPU
  cpu_bus_if.decoder  bus
);

  logic [23:0] byte_addr;
  logic [23:0] region;
  logic [23:0] ram_base;
  logic        low_region;
  logic        periph;
  logic        via_cs;

  // ======================================================================
  // Region decode
  // ======================================================================
  assign byte_addr  = {cpu_a, 1'b0};
  assign region     = byte_addr & `MAC_REGION_MASK;
  assign low_region = (byte_addr & `MAC_LOW_MASK) == 24'h000000;  // 0x000000..0x3FFFFF
  assign periph     = cpu_a[`MAC_PERIPH_BIT];
  assign via_cs     = region == `MAC_VIA_BASE;

  always_comb begin
    rom_cs = 1'b0;
    ram_cs = 1'b0;
    if (region == `MAC_ROM_BASE)
      rom_cs = 1'b1;                  // ROM visible here in both maps
    if (low_region) begin
      if (overlay)
        rom_cs = 1'b1;                // Boot map, ROM at 0
      else
        ram_cs = 1'b1;                // Normal map, RAM at 0
    end
    // RAM moves up while ROM sits at 0
    if (overlay && region == `MAC_RAM_ALT_BASE)
      ram_cs = 1'b1;
  end

  // RAM base follows the overlay bit
  assign ram_base = overlay ? `MAC_RAM_ALT_BASE : 24'h000000;
  assign ram_addr = byte_addr - ram_base;

  // 6800-style cycle for the whole upper half
  assign vpa_n = ~periph | cpu_as_n;

  // ======================================================================
  // VIA access toward the register block
  // ======================================================================
  assign bus.sel     = via_cs & ~cpu_as_n;
  assign bus.write   = ~cpu_rw;
  assign bus.reg_idx = via_reg_e'(cpu_a[12:9]);  // RS3..RS0
  assign bus.wdata   = cpu_dout[15:8];           // VIA sits on the upper byte
  assign bus.upper   = ~cpu_uds_n;

  // Read data mux, VIA first then other peripherals
  always_comb begin
    if (via_cs)
      cpu_din = {bus.rdata, `MAC_VIA_LOW_BYTE};
    else if (periph)
      cpu_din = 16'h0000;             // SCC, IWM, mouse and the rest read zero
    else if (ram_cs)
      cpu_din = ram_dout;
    else
      cpu_din = rom_dout;             // ROM and unmapped low space
  end

endmodule

`default_nettype wire

//--- vblank_timebase.sv
`default_nettype none
`include "mac_io_params.svh"

module vblank_timebase (
  input  wire  clk_cpu,
  input  wire  reset,
  input  wire  vsync,         // From video timing, active low
  output logic frame_pulse,   // One cycle per vsync falling edge
  output logic second_pulse   // With every sixtieth frame pulse
);

  localparam int CNT_W = $clog2(`MAC_VSYNC_PER_SEC);
  localparam logic [CNT_W-1:0] LAST_FRAME = CNT_W'(`MAC_VSYNC_PER_SEC - 1);

  logic             vsync_q;    // First sample
  logic             vsync_qq;   // Previous sample
  logic [CNT_W-1:0] frame_cnt;

  // Sample vsync into the CPU domain
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      vsync_q  <= 1'b0;   // Low start avoids a false edge
      vsync_qq <= 1'b0;
    end else begin
      vsync_q  <= vsync;
      vsync_qq <= vsync_q;
    end
  end

  assign frame_pulse  = vsync_qq & ~vsync_q;              // High to low seen
  assign second_pulse = frame_pulse & (frame_cnt == LAST_FRAME);

  // Frames within the current second
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      frame_cnt <= '0;
    end else if (frame_pulse) begin
      if (frame_cnt == LAST_FRAME)
        frame_cnt <= '0;                                  // Wrap after sixty
      else
        frame_cnt <= frame_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- via_regs.sv
`default_nettype none
`include "mac_io_params.svh"

module via_regs import mac_io_pkg::*; (
  input  wire      clk_cpu,
  input  wire      reset,
  input  wire      frame_pulse,   // Sets VBLANK
  input  wire      second_pulse,  // Sets ONESEC
  input  wire      hsync,
  cpu_bus_if.via   bus,
  output logic     overlay,       // ROM mapped at 0
  output logic     audio,         // Sound enable line, port B bit 7
  output logic     via_irq_n      // To CPU interrupt encoder
);

  logic [7:0]  port_a;
  logic [7:0]  port_b;
  logic        ddr_b0;        // Only implemented direction bit
  logic [7:0]  acr;
  logic [7:0]  sr;
  logic [15:0] t1_count;
  logic [15:0] t1_latch;
  logic [15:0] t2_count;
  logic [7:0]  t2_latch_low;
  via_flags_t  ifr;
  via_flags_t  ier;
  logic        access;
  logic        wr;
  logic        rd;
  logic        irq_any;

  // Strobe held over several clocks, updates are idempotent
  assign access = bus.sel & bus.upper;
  assign wr     = access & bus.write;
  assign rd     = access & ~bus.write;

  // ======================================================================
  // Register writes, read side effects and timebase events
  // ======================================================================
  always_ff @(posedge clk_cpu) begin
    if (reset) begin
      port_a       <= `MAC_PORTA_RESET;
      port_b       <= `MAC_PORTB_RESET;
      ddr_b0       <= 1'b1;
      acr          <= 8'h00;
      sr           <= 8'h00;
      t1_count     <= 16'h0000;
      t1_latch     <= 16'h0000;
      t2_count     <= 16'h0000;
      t2_latch_low <= 8'h00;
      ifr          <= '0;
      ier          <= '0;
    end else begin
      if (wr) begin
        case (bus.reg_idx)
          VIA_PORTB: port_b <= bus.wdata;
          VIA_DDRB:  ddr_b0 <= bus.wdata[0];
          VIA_T1CL:  t1_count[7:0]  <= bus.wdata;
          VIA_T1CH:  t1_count[15:8] <= bus.wdata;
          VIA_T1LL:  t1_latch[7:0]  <= bus.wdata;
          VIA_T1LH:  t1_latch[15:8] <= bus.wdata;
          VIA_T2CL:  t2_latch_low   <= bus.wdata;  // Held until the high write
          VIA_T2CH: begin                          // Arm timer 2
            t2_count       <= {bus.wdata, t2_latch_low};
            ifr[IRQ_T2]    <= 1'b0;
          end
          VIA_SR: begin
            sr <= bus.wdata;
            // Byte handed to the keyboard side
            if (acr[4:2] == `MAC_ACR_SHIFT_OUT)
              ifr[IRQ_KEYREADY] <= 1'b1;
          end
          VIA_ACR:   acr <= bus.wdata;
          VIA_IFR:   ifr <= ifr & ~bus.wdata[6:0];  // Write one to clear
          VIA_IER: begin
            if (bus.wdata[7])
              ier <= ier | bus.wdata[6:0];          // Set selected enables
            else
              ier <= ier & ~bus.wdata[6:0];         // Clear selected enables
          end
          VIA_PORTA: port_a <= bus.wdata;
          default: ;                                // DDRA, PCR fixed
        endcase
      end

      if (rd) begin
        case (bus.reg_idx)
          VIA_PORTB: begin
            ifr[IRQ_KEYCLK] <= 1'b0;
            ifr[IRQ_KEYBIT] <= 1'b0;
          end
          VIA_T2CL: ifr[IRQ_T2]       <= 1'b0;
          VIA_SR:   ifr[IRQ_KEYREADY] <= 1'b0;
          VIA_PORTA: begin
            ifr[IRQ_ONESEC] <= 1'b0;
            ifr[IRQ_VBLANK] <= 1'b0;
          end
          default: ;
        endcase
      end

      // Events after CPU clears so a coincident event is kept
      if (frame_pulse)
        ifr[IRQ_VBLANK] <= 1'b1;
      if (second_pulse)
        ifr[IRQ_ONESEC] <= 1'b1;
    end
  end

  assign irq_any   = |(ifr & ier);
  assign via_irq_n = ~irq_any;
  assign overlay   = port_a[4];
  assign audio     = port_b[7];

  // ======================================================================
  // Read data
  // ======================================================================
  always_comb begin
    case (bus.reg_idx)
      VIA_PORTB: bus.rdata = {port_b[7], ~hsync, 3'b000, port_b[2:1],
                              ddr_b0 & port_b[0]};  // Mouse and RTC in read zero
      VIA_DDRB:  bus.rdata = {`MAC_DDRB_FIXED, ddr_b0};
      VIA_DDRA:  bus.rdata = `MAC_DDRA_VALUE;
      VIA_T1CL:  bus.rdata = t1_count[7:0];
      VIA_T1CH:  bus.rdata = t1_count[15:8];
      VIA_T1LL:  bus.rdata = t1_latch[7:0];
      VIA_T1LH:  bus.rdata = t1_latch[15:8];
      VIA_T2CL:  bus.rdata = t2_count[7:0];
      VIA_T2CH:  bus.rdata = t2_count[15:8];
      VIA_SR:    bus.rdata = sr;
      VIA_ACR:   bus.rdata = acr;
      VIA_PCR:   bus.rdata = 8'h00;
      VIA_IFR:   bus.rdata = {irq_any, ifr};        // Bit 7 is the summary
      VIA_IER:   bus.rdata = {1'b0, ier};
      VIA_PORTA: bus.rdata = {1'b0, port_a[6:0]};   // SCC wait request reads 0
      default:   bus.rdata = `MAC_VIA_UNMAPPED;
    endcase
  end

endmodule

`default_nettype wire

//--- mac_io.sv
`default_nettype none

module mac_io (
  input  wire         clk_cpu,
  input  wire         reset,
  input  wire  [23:1] cpu_a,      // 68000 word address
  input  wire         cpu_as_n,
  input  wire         cpu_rw,
  input  wire         cpu_uds_n,
  input  wire  [15:0] cpu_dout,   // Data from CPU
  input  wire  [15:0] ram_dout,
  input  wire  [15:0] rom_dout,
  input  wire         vsync,
  input  wire         hsync,
  output logic [15:0] cpu_din,    // Data to CPU
  output logic        ram_cs,
  output logic        rom_cs,
  output logic        vpa_n,
  output logic [23:0] ram_addr,
  output logic        overlay,
  output logic        audio,
  output logic        via_irq_n
);

  logic frame_pulse;
  logic second_pulse;

  cpu_bus_if via_bus ();  // Decoder to VIA

  // ======================================================================
  // Address decode and read mux
  // ======================================================================
  bus_decode u_decode (
    .cpu_a     (cpu_a),
    .cpu_as_n  (cpu_as_n),
    .cpu_rw    (cpu_rw),
    .cpu_uds_n (cpu_uds_n),
    .cpu_dout  (cpu_dout),
    .ram_dout  (ram_dout),
    .rom_dout  (rom_dout),
    .overlay   (overlay),     // Back from port A
    .ram_cs    (ram_cs),
    .rom_cs    (rom_cs),
    .vpa_n     (vpa_n),
    .ram_addr  (ram_addr),
    .cpu_din   (cpu_din),
    .bus       (via_bus)
  );

  // Vertical blank and one second events
  vblank_timebase u_timebase (
    .clk_cpu      (clk_cpu),
    .reset        (reset),
    .vsync        (vsync),
    .frame_pulse  (frame_pulse),
    .second_pulse (second_pulse)
  );

  via_regs u_via (
    .clk_cpu      (clk_cpu),
    .reset        (reset),
    .frame_pulse  (frame_pulse),
    .second_pulse (second_pulse),
    .hsync        (hsync),
    .bus          (via_bus),
    .overlay      (overlay),
    .audio        (audio),
    .via_irq_n    (via_irq_n)
  );

endmodule

`default_nettype wire

//--- tb_clock.sv
`default_nettype none

// Free-running CPU clock with a power-on reset
module tb_clock #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_cpu,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_cpu = 1'b0;
    forever #(PERIOD_NS / 2) clk_cpu = ~clk_cpu;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_cpu);
    reset <= 1'b0;  // Released on a rising edge
  end

endmodule

`default_nettype wire

//--- mac_io_props.sv
`default_nettype none

// Bound into mac_io, sees internal IER and the frame pulse
module mac_io_props import mac_io_pkg::*; (
  input wire             clk_cpu,
  input wire             reset,
  input wire via_flags_t ier,
  input wire             via_irq_n,
  input wire             ram_cs,
  input wire             rom_cs,
  input wire             frame_pulse
);
  timeunit 1ns;
  timeprecision 100ps;

  // No enables, no interrupt
  irq_needs_enable: assert property (
    @(posedge clk_cpu) disable iff (reset) (ier == '0) |-> via_irq_n
  ) else $error("via_irq_n low while IER is zero");

  // One memory select at a time
  cs_exclusive: assert property (
    @(posedge clk_cpu) disable iff (reset) !(ram_cs && rom_cs)
  ) else $error("ram_cs and rom_cs high together");

  frame_pulse_single: assert property (
    @(posedge clk_cpu) disable iff (reset) frame_pulse |=> !frame_pulse
  ) else $error("frame_pulse longer than one cycle");  // Edge detect broken

endmodule

`default_nettype wire

//--- mac_io_tb.sv
`default_nettype none

module mac_io_tb import mac_io_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  // ======================================================================
  // Operation table
  // ======================================================================
  typedef enum logic [2:0] {OP_WR, OP_RD, OP_MAP, OP_IRQ, OP_VSYNC} op_kind_e;

  typedef struct packed {
    op_kind_e    kind;
    logic [23:0] addr;   // Byte address
    logic [7:0]  data;   // Write byte, {ram,rom} selects, irq level or pulse count
    logic [23:0] exp;    // cpu_din, ram_addr, or latency check flag
  } op_t;

  // VIA register byte address, RS3..RS0 on A12..A9
  function automatic logic [23:0] via_addr(input via_reg_e r);
    return {11'h700, r, 9'h000};
  endfunction

  localparam int NUM_OPS = 51;
  localparam op_t OPS [NUM_OPS] = '{
    '{OP_MAP,   24'h000000,              8'h01, 24'h000000},  // Overlay, ROM at 0
    '{OP_RD,    24'h000000,              8'h00, 24'h004E71},
    '{OP_WR,    via_addr(VIA_PORTA),     8'h7F, 24'h0},
    '{OP_MAP,   24'h600010,              8'h02, 24'h000010},  // RAM moved up
    '{OP_RD,    24'h600010,              8'h00, 24'h00A55A},
    '{OP_WR,    via_addr(VIA_PORTA),     8'h6F, 24'h0},       // Overlay off
    '{OP_MAP,   24'h000000,              8'h02, 24'h000000},
    '{OP_MAP,   24'h400000,              8'h01, 24'h000000},
    '{OP_RD,    via_addr(VIA_PORTA),     8'h00, 24'h006FEF},
    '{OP_WR,    via_addr(VIA_PORTA),     8'h7F, 24'h0},
    '{OP_WR,    via_addr(VIA_ACR),       8'h5A, 24'h0},       // Register readback
    '{OP_RD,    via_addr(VIA_ACR),       8'h00, 24'h005AEF},
    '{OP_WR,    via_addr(VIA_T1LL),      8'h34, 24'h0},
    '{OP_WR,    via_addr(VIA_T1LH),      8'h12, 24'h0},
    '{OP_RD,    via_addr(VIA_T1LL),      8'h00, 24'h0034EF},
    '{OP_RD,    via_addr(VIA_T1LH),      8'h00, 24'h0012EF},
    '{OP_WR,    via_addr(VIA_DDRB),      8'h00, 24'h0},
    '{OP_RD,    via_addr(VIA_DDRB),      8'h00, 24'h0086EF},  // Fixed 1000011 above bit 0
    '{OP_RD,    via_addr(VIA_PORTA_HS),  8'h00, 24'h00BEEF},
    '{OP_RD,    24'h900000,              8'h00, 24'h000000},  // Unmapped peripheral
    '{OP_WR,    via_addr(VIA_IER),       8'h83, 24'h0},       // Set ONESEC, VBLANK
    '{OP_WR,    via_addr(VIA_IER),       8'h01, 24'h0},       // Clear ONESEC
    '{OP_RD,    via_addr(VIA_IER),       8'h00, 24'h0002EF},
    '{OP_IRQ,   24'h0,                   8'h01, 24'h0},
    '{OP_VSYNC, 24'h0,                   8'd1,  24'h1},       // First frame, timed
    '{OP_RD,    via_addr(VIA_IFR),       8'h00, 24'h0082EF},
    '{OP_WR,    via_addr(VIA_IFR),       8'h02, 24'h0},
    '{OP_IRQ,   24'h0,                   8'h01, 24'h0},
    '{OP_VSYNC, 24'h0,                   8'd59, 24'h0},       // Completes the second
    '{OP_RD,    via_addr(VIA_IFR),       8'h00, 24'h0083EF},
    '{OP_RD,    via_addr(VIA_PORTA),     8'h00, 24'h007FEF},  // Clears both
    '{OP_RD,    via_addr(VIA_IFR),       8'h00, 24'h0000EF},
    '{OP_WR,    via_addr(VIA_T2CL),      8'h78, 24'h0},       // Timer 2
    '{OP_WR,    via_addr(VIA_T2CH),      8'h56, 24'h0},
    '{OP_RD,    via_addr(VIA_T2CH),      8'h00, 24'h0056EF},
    '{OP_RD,    via_addr(VIA_T2CL),      8'h00, 24'h0078EF},
    '{OP_WR,    via_addr(VIA_ACR),       8'h1C, 24'h0},       // Shift out mode
    '{OP_WR,    via_addr(VIA_SR),        8'hC3, 24'h0},
    '{OP_WR,    via_addr(VIA_IER),       8'h84, 24'h0},
    '{OP_RD,    via_addr(VIA_IFR),       8'h00, 24'h0084EF},
    '{OP_IRQ,   24'h0,                   8'h00, 24'h0},
    '{OP_WR,    via_addr(VIA_IFR),       8'h04, 24'h0},
    '{OP_IRQ,   24'h0,                   8'h01, 24'h0},
    '{OP_WR,    via_addr(VIA_SR),        8'h3C, 24'h0},
    '{OP_RD,    via_addr(VIA_SR),        8'h00, 24'h003CEF},  // Clears KEYREADY
    '{OP_RD,    via_addr(VIA_IFR),       8'h00, 24'h0000EF},
    '{OP_WR,    via_addr(VIA_IER),       8'h7F, 24'h0},
    '{OP_RD,    via_addr(VIA_IER),       8'h00, 24'h0000EF},
    '{OP_VSYNC, 24'h0,                   8'd1,  24'h0},       // Flag with all enables off
    '{OP_IRQ,   24'h0,                   8'h01, 24'h0},
    '{OP_RD,    via_addr(VIA_IFR),       8'h00, 24'h0002EF}   // Summary bit stays low
  };

  // Longest entry is the 59 frame burst, up to 14 cycles per frame
  localparam int MAX_OP_CYCLES = 60 * 14;
  localparam int LIMIT         = 16 + NUM_OPS * MAX_OP_CYCLES + 200;

  logic        clk_cpu;
  logic        reset;
  logic [23:1] cpu_a;
  logic        cpu_as_n;
  logic        cpu_rw;
  logic        cpu_uds_n;
  logic [15:0] cpu_dout;
  logic [15:0] ram_dout;
  logic [15:0] rom_dout;
  logic        vsync;
  logic        hsync;
  logic [15:0] cpu_din;
  logic        ram_cs;
  logic        rom_cs;
  logic        vpa_n;
  logic [23:0] ram_addr;
  logic        overlay;
  logic        audio;
  logic        via_irq_n;
  int          cycles;

  tb_clock #(.PERIOD_NS(100), .RESET_CYCLES(16)) clock_i (.clk_cpu(clk_cpu), .reset(reset));

  mac_io mac_io_i (.*);

  bind mac_io mac_io_props props_i (
    .clk_cpu     (clk_cpu),
    .reset       (reset),
    .ier         (u_via.ier),
    .via_irq_n   (via_irq_n),
    .ram_cs      (ram_cs),
    .rom_cs      (rom_cs),
    .frame_pulse (frame_pulse)
  );

  // ======================================================================
  // Tasks
  // ======================================================================
  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    if (got !== expected) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, expected);
      $display("** FAIL **");
      $fatal(1, "value mismatch");
    end
  endtask

  // One 68000 cycle, strobes held for four edges
  task automatic bus_cycle(input op_t op);
    logic [7:0] low_bits;
    low_bits = 8'($urandom);
    @(posedge clk_cpu);
    cpu_a     <= op.addr[23] ? {op.addr[23:9], low_bits} : op.addr[23:1];  // Peripherals ignore A8..A1
    cpu_as_n  <= 1'b0;
    cpu_uds_n <= 1'b0;
    cpu_rw    <= (op.kind != OP_WR);
    cpu_dout  <= {op.data, 8'h00};
    repeat (3) @(posedge clk_cpu);
    @(negedge clk_cpu);  // Mid cycle sample
    compare_value("vpa_n", {31'h0, vpa_n}, {31'h0, ~op.addr[23]});  // Peripheral half
    if (op.kind == OP_RD)
      compare_value("cpu_din", {16'h0, cpu_din}, {16'h0, op.exp[15:0]});
    if (op.kind == OP_MAP) begin
      compare_value("ram_cs", {31'h0, ram_cs}, {31'h0, op.data[1]});
      compare_value("rom_cs", {31'h0, rom_cs}, {31'h0, op.data[0]});
      if (op.data[1])
        compare_value("ram_addr", {8'h0, ram_addr}, {8'h0, op.exp});
    end
    @(posedge clk_cpu);
    cpu_as_n  <= 1'b1;
    cpu_uds_n <= 1'b1;
    cpu_rw    <= 1'b1;
    @(negedge clk_cpu);
    compare_value("vpa_n", {31'h0, vpa_n}, 32'h1);  // Strobe released
  endtask

  // Falling edges on vsync with random low and high widths
  task automatic pulse_vsync(input logic [7:0] count, input logic timed);
    int low_w;
    int high_w;
    repeat (count) begin
      low_w  = 2 + $urandom % 4;
      high_w = 2 + $urandom % 4;
      @(posedge clk_cpu);
      vsync <= 1'b0;
      if (timed) begin
        repeat (3) @(negedge clk_cpu);  // VBLANK enabled, so irq shows the flag
        compare_value("via_irq_n", {31'h0, via_irq_n}, 32'h0);
      end
      repeat (low_w) @(posedge clk_cpu);
      vsync <= 1'b1;
      repeat (high_w) @(posedge clk_cpu);
    end
  endtask

  task automatic apply_op(input op_t op);
    case (op.kind)
      OP_VSYNC: pulse_vsync(op.data, op.exp[0]);
      OP_IRQ: begin
        @(negedge clk_cpu);
        compare_value("via_irq_n", {31'h0, via_irq_n}, {31'h0, op.data[0]});
      end
      default: bus_cycle(op);
    endcase
  endtask

  // ======================================================================
  // Stimulus and verdict
  // ======================================================================
  initial begin
    cpu_a     = '0;
    cpu_as_n  = 1'b1;
    cpu_rw    = 1'b1;
    cpu_uds_n = 1'b1;
    cpu_dout  = 16'h0000;
    ram_dout  = 16'hA55A;  // Fixed memory words
    rom_dout  = 16'h4E71;
    vsync     = 1'b1;
    hsync     = 1'b1;
    void'($urandom(32'ha1541d08));
    @(negedge reset);
    @(negedge clk_cpu);
    compare_value("via_irq_n", {31'h0, via_irq_n}, 32'h1);  // Reset state
    compare_value("overlay", {31'h0, overlay}, 32'h1);
    compare_value("audio", {31'h0, audio}, 32'h1);
    foreach (OPS[n])
      apply_op(OPS[n]);
    $display("** PASS **");
    $finish;
  end

  // Watchdog
  always @(posedge clk_cpu) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout, the test did not finish within %0d cycles", LIMIT);
      $display("** FAIL **");
      $fatal(1, "timeout");
    end
  end

  initial cycles = 0;

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
mac_io_pkg.sv
cpu_bus_if.sv
bus_decode.sv
vblank_timebase.sv
via_regs.sv
mac_io.sv
tb_clock.sv
mac_io_props.sv
mac_io_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       ?= mac_io_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
BIN        = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
